// ==== src.f ====
+incdir+source
source/procyon_pkg.sv
source/rs_dispatch_if.sv
source/sync_fifo.sv
source/dispatch.sv
source/register_map.sv
source/reorder_buffer.sv
source/reservation_station.sv
source/ieu.sv
source/procyon.sv
verification/procyon_assertions.sv
verification/procyon_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = procyon_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/procyon_tb.sv ====
`timescale 1ns/1ns

module procyon_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int N_INDEP         = 8;
    localparam int N_CHAIN         = 12;
    localparam int N_OPS           = 18;
    localparam int N_BURST         = 24;
    localparam int N_ZERO          = 6;
    localparam int TOTAL_INSNS     = N_INDEP + N_CHAIN + N_OPS + N_BURST + N_ZERO;
    localparam int CYCLES_PER_INSN = 20;
    localparam logic [6:0] OP      = 7'b0110011;
    localparam logic [6:0] OP_IMM  = 7'b0010011;
    // ADD, SUB, XOR, OR, AND; entries 1 to 4 also serve the immediate forms
    localparam logic [2:0] R_FUNCT3 [0:4] = '{3'b000, 3'b000, 3'b100, 3'b110, 3'b111};

    logic        clk;
    logic        i_reset;
    logic        i_insn_valid;
    logic [31:0] i_insn;
    logic        o_insn_ready;
    logic        o_retire_valid;
    logic [4:0]  o_retire_rdest;
    logic [31:0] o_retire_data;

    logic [31:0] lfsr_state;
    logic [31:0] model_regs [0:31];
    logic [36:0] expected_q [$];
    logic [36:0] retire_entry;
    logic        saw_not_ready;

    procyon dut_i (
        .clk(clk),
        .i_reset(i_reset),
        .i_insn_valid(i_insn_valid),
        .i_insn(i_insn),
        .o_insn_ready(o_insn_ready),
        .o_retire_valid(o_retire_valid),
        .o_retire_rdest(o_retire_rdest),
        .o_retire_data(o_retire_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, OP_IMM};
    endfunction

    // Expected retire as {rdest, data}, computed from the RV32I rules
    function automatic logic [36:0] model_result(input logic [31:0] insn);
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        opcode = insn[6:0];
        rd     = insn[11:7];
        a      = model_regs[insn[19:15]];
        b      = (opcode == OP_IMM) ? {{20{insn[31]}}, insn[31:20]} : model_regs[insn[24:20]];
        case (insn[14:12])
            3'b000:  result = (opcode == OP && insn[30]) ? a - b : a + b;
            3'b100:  result = a ^ b;
            3'b110:  result = a | b;
            3'b111:  result = a & b;
            default: result = '0;
        endcase
        if (opcode != OP && opcode != OP_IMM) begin
            rd = '0;
        end
        if (rd == '0) begin
            result = '0;
        end
        return {rd, result};
    endfunction

    // Called at a falling edge, returns at the falling edge after the transfer
    task automatic send_insn(input logic [31:0] insn);
        logic [36:0] expected;
        expected = model_result(insn);
        if (expected[36:32] != '0) begin
            model_regs[expected[36:32]] = expected[31:0];
        end
        expected_q.push_back(expected);
        i_insn_valid = 1'b1;
        i_insn       = insn;
        while (!o_insn_ready) begin
            saw_not_ready = 1'b1;
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic wait_for_retire();
        i_insn_valid = 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (!i_reset && o_retire_valid) begin
            if (expected_q.size() == 0) begin
                $display("[ERROR] %0t ns: an instruction retired with none outstanding", $time);
                abort_run();
            end else begin
                retire_entry = expected_q.pop_front();
                check_value("o_retire_rdest", 32'(o_retire_rdest), 32'(retire_entry[36:32]));
                check_value("o_retire_data", o_retire_data, retire_entry[31:0]);
            end
        end
    end

    task automatic idle_after_reset();
        check_value("o_retire_valid", 32'(o_retire_valid), 32'd0);
        check_value("o_insn_ready", 32'(o_insn_ready), 32'd1);
    endtask

    task automatic independent_addi();
        for (int n = 0; n < N_INDEP; n++) begin
            send_insn(i_type(12'(random_bits(12)), 5'd0, 3'b000, 5'(n + 1)));
        end
        wait_for_retire();
    endtask

    // Each instruction reads the previous destination
    task automatic run_chain(input int length);
        logic [4:0] prev;
        logic [4:0] rd;
        prev = 5'd1;
        for (int n = 0; n < length; n++) begin
            rd = 5'(random_bits(5));
            if (rd == '0) begin
                rd = 5'd9;
            end
            if (n % 2 == 0) begin
                send_insn(i_type(12'(random_bits(12)), prev, 3'b000, rd));
            end else begin
                send_insn(r_type((n % 4 == 1) ? 7'h20 : 7'h00, 5'(random_bits(5)), prev,
                                 3'b000, rd));
            end
            prev = rd;
        end
    endtask

    task automatic dependent_chain();
        run_chain(N_CHAIN);
        wait_for_retire();
    endtask

    task automatic alu_operations();
        logic [4:0] rd;
        logic [4:0] rs1;
        for (int rep = 0; rep < N_OPS / 9; rep++) begin
            for (int k = 0; k < 9; k++) begin
                rd  = 5'(random_bits(5));
                rs1 = 5'(random_bits(5));
                if (k < 5) begin
                    send_insn(r_type((k == 1) ? 7'h20 : 7'h00, 5'(random_bits(5)), rs1,
                                     R_FUNCT3[k], rd));
                end else begin
                    send_insn(i_type(12'(random_bits(12)), rs1, R_FUNCT3[k - 4], rd));
                end
            end
        end
        wait_for_retire();
    endtask

    task automatic backpressure_burst();
        saw_not_ready = 1'b0;
        run_chain(N_BURST);
        wait_for_retire();
        if (!saw_not_ready) begin
            $display("[ERROR] %0t ns: o_insn_ready never dropped during the burst", $time);
            abort_run();
        end
    endtask

    task automatic x0_and_unsupported();
        send_insn(i_type(12'(random_bits(12)), 5'd0, 3'b000, 5'd0));
        send_insn(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        // Load and branch opcodes are not executed
        send_insn({25'(random_bits(25)), 7'b0000011});
        send_insn({25'(random_bits(25)), 7'b1100011});
        send_insn(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd6));
        send_insn(i_type(12'h123, 5'd0, 3'b000, 5'd7));
        wait_for_retire();
    endtask

    initial begin
        #((TOTAL_INSNS * CYCLES_PER_INSN + 20) * CLK_PERIOD);
        $display("[ERROR] %0t ns: timeout, the tests did not finish in time", $time);
        abort_run();
    end

    initial begin
        lfsr_state    = 32'd78;
        i_reset       = 1'b1;
        i_insn_valid  = 1'b0;
        i_insn        = '0;
        saw_not_ready = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        idle_after_reset();
        independent_addi();
        dependent_chain();
        alu_operations();
        backpressure_burst();
        x0_and_unsupported();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verification/procyon_assertions.sv ====
`timescale 1ns/1ns
`include "procyon_defines.svh"

module procyon_assertions #(
    parameter int CNT_WIDTH = $clog2(`ROB_DEPTH) + 1
) (
    input logic                      clk,
    input logic                      i_reset,
    input logic [CNT_WIDTH-1:0]      i_count,
    input procyon_pkg::procyon_tag_t i_head,
    input procyon_pkg::procyon_tag_t i_tail,
    input logic                      i_rob_en,
    input logic                      i_rob_full,
    input procyon_pkg::procyon_cdb_t i_cdb,
    input logic                      i_retire
);

    // Slots that saw their CDB result since they were last allocated
    logic [`ROB_DEPTH-1:0] completed;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            completed <= '0;
        end else begin
            if (i_rob_en && !i_rob_full) begin
                completed[i_tail] <= 1'b0;
            end
            if (i_cdb.valid) begin
                completed[i_cdb.tag] <= 1'b1;
            end
        end
    end

    count_bound: assert property (@(posedge clk) disable iff (i_reset)
        i_count <= CNT_WIDTH'(`ROB_DEPTH) &&
        procyon_pkg::procyon_tag_t'(i_tail - i_head) == procyon_pkg::procyon_tag_t'(i_count))
        else $error("ROB count above its depth or out of step with its pointers");

    no_alloc_when_full: assert property (@(posedge clk) disable iff (i_reset)
        !(i_rob_en && i_rob_full))
        else $error("ROB allocation while full");

    retire_when_done: assert property (@(posedge clk) disable iff (i_reset)
        i_retire |-> completed[i_head])
        else $error("ROB retired a head entry that was not done");

endmodule

bind reorder_buffer procyon_assertions rob_assertions_i (
    .clk(clk),
    .i_reset(i_reset),
    .i_count(count),
    .i_head(head),
    .i_tail(tail),
    .i_rob_en(i_rob_en),
    .i_rob_full(o_rob_full),
    .i_cdb(i_cdb),
    .i_retire(retire)
);

// ==== source/procyon.sv ====
`timescale 1ns/1ns
`include "procyon_defines.svh"

module procyon (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_insn_valid,
    input  logic [`DATA_WIDTH-1:0]     i_insn,
    output logic                       o_insn_ready,
    output logic                       o_retire_valid,
    output procyon_pkg::procyon_reg_t  o_retire_rdest,
    output procyon_pkg::procyon_data_t o_retire_data
);

    logic                       insn_fifo_full;
    logic                       insn_fifo_empty;
    logic                       insn_fifo_rd_en;
    logic [`DATA_WIDTH-1:0]     insn_fifo_rd_data;

    procyon_pkg::procyon_reg_t  regmap_rsrc  [0:1];
    logic                       regmap_busy  [0:1];
    procyon_pkg::procyon_tag_t  regmap_tag   [0:1];
    procyon_pkg::procyon_data_t regmap_data  [0:1];
    logic                       regmap_rename_en;
    procyon_pkg::procyon_reg_t  regmap_rename_rdest;

    logic                       rob_full;
    procyon_pkg::procyon_tag_t  rob_tag;
    logic                       rob_src_rdy    [0:1];
    procyon_pkg::procyon_data_t rob_src_data   [0:1];
    procyon_pkg::procyon_tag_t  rob_lookup_tag [0:1];
    logic                       rob_en;
    procyon_pkg::procyon_reg_t  rob_rdest;
    procyon_pkg::procyon_tag_t  retire_tag;

    logic                         fu_valid;
    procyon_pkg::procyon_alu_op_t fu_alu_op;
    procyon_pkg::procyon_data_t   fu_src_a;
    procyon_pkg::procyon_data_t   fu_src_b;
    procyon_pkg::procyon_tag_t    fu_tag;
    procyon_pkg::procyon_cdb_t    cdb;

    rs_dispatch_if rs_dispatch ();

    assign o_insn_ready = ~insn_fifo_full;

    sync_fifo #(
        .DATA_WIDTH(`DATA_WIDTH),
        .FIFO_DEPTH(`INSN_FIFO_DEPTH)
    ) insn_fifo (
        .clk(clk),
        .i_reset(i_reset),
        .i_fifo_wr_en(i_insn_valid),
        .i_fifo_data(i_insn),
        .o_fifo_full(insn_fifo_full),
        .i_fifo_rd_en(insn_fifo_rd_en),
        .o_fifo_data(insn_fifo_rd_data),
        .o_fifo_empty(insn_fifo_empty)
    );

    dispatch dispatch_inst (
        .i_insn_fifo_empty(insn_fifo_empty),
        .i_insn_fifo_data(insn_fifo_rd_data),
        .o_insn_fifo_rd_en(insn_fifo_rd_en),
        .o_regmap_rsrc(regmap_rsrc),
        .i_regmap_busy(regmap_busy),
        .i_regmap_tag(regmap_tag),
        .i_regmap_data(regmap_data),
        .o_regmap_rename_en(regmap_rename_en),
        .o_regmap_rename_rdest(regmap_rename_rdest),
        .i_rob_full(rob_full),
        .i_rob_tag(rob_tag),
        .i_rob_src_rdy(rob_src_rdy),
        .i_rob_src_data(rob_src_data),
        .o_rob_lookup_tag(rob_lookup_tag),
        .o_rob_en(rob_en),
        .o_rob_rdest(rob_rdest),
        .rs_if(rs_dispatch.dispatch)
    );

    register_map register_map_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_rsrc(regmap_rsrc),
        .o_busy(regmap_busy),
        .o_tag(regmap_tag),
        .o_data(regmap_data),
        .i_rename_en(regmap_rename_en),
        .i_rename_rdest(regmap_rename_rdest),
        .i_rename_tag(rob_tag),
        .i_retire_en(o_retire_valid),
        .i_retire_rdest(o_retire_rdest),
        .i_retire_tag(retire_tag),
        .i_retire_data(o_retire_data)
    );

    reorder_buffer rob_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_rob_en(rob_en),
        .i_rob_rdest(rob_rdest),
        .o_rob_full(rob_full),
        .o_rob_tag(rob_tag),
        .i_lookup_tag(rob_lookup_tag),
        .o_src_rdy(rob_src_rdy),
        .o_src_data(rob_src_data),
        .i_cdb(cdb),
        .o_retire_en(o_retire_valid),
        .o_retire_rdest(o_retire_rdest),
        .o_retire_tag(retire_tag),
        .o_retire_data(o_retire_data)
    );

    reservation_station #(
        .RS_DEPTH(`RS_DEPTH)
    ) rs_ieu_inst (
        .clk(clk),
        .i_reset(i_reset),
        .rs_if(rs_dispatch.station),
        .i_cdb(cdb),
        .o_fu_valid(fu_valid),
        .o_fu_alu_op(fu_alu_op),
        .o_fu_src_a(fu_src_a),
        .o_fu_src_b(fu_src_b),
        .o_fu_tag(fu_tag)
    );

    ieu ieu_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_fu_valid(fu_valid),
        .i_fu_alu_op(fu_alu_op),
        .i_fu_src_a(fu_src_a),
        .i_fu_src_b(fu_src_b),
        .i_fu_tag(fu_tag),
        .o_cdb(cdb)
    );

endmodule

// ==== source/ieu.sv ====
`timescale 1ns/1ns

module ieu (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_fu_valid,
    input  procyon_pkg::procyon_alu_op_t i_fu_alu_op,
    input  procyon_pkg::procyon_data_t   i_fu_src_a,
    input  procyon_pkg::procyon_data_t   i_fu_src_b,
    input  procyon_pkg::procyon_tag_t    i_fu_tag,
    output procyon_pkg::procyon_cdb_t    o_cdb
);

    procyon_pkg::procyon_data_t result;

    always_comb begin
        case (i_fu_alu_op)
            procyon_pkg::ALU_ADD: result = i_fu_src_a + i_fu_src_b;
            procyon_pkg::ALU_SUB: result = i_fu_src_a - i_fu_src_b;
            procyon_pkg::ALU_XOR: result = i_fu_src_a ^ i_fu_src_b;
            procyon_pkg::ALU_OR:  result = i_fu_src_a | i_fu_src_b;
            procyon_pkg::ALU_AND: result = i_fu_src_a & i_fu_src_b;
            default:              result = '0;
        endcase
    end

    // One cycle from issue to CDB, never stalls
    always_ff @(posedge clk) begin
        o_cdb.tag  <= i_fu_tag;
        o_cdb.data <= result;
        if (i_reset) begin
            o_cdb.valid <= 1'b0;
        end else begin
            o_cdb.valid <= i_fu_valid;
        end
    end

endmodule

// ==== source/reservation_station.sv ====
`timescale 1ns/1ns

module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         i_reset,
    rs_dispatch_if.station               rs_if,
    input  procyon_pkg::procyon_cdb_t    i_cdb,
    output logic                         o_fu_valid,
    output procyon_pkg::procyon_alu_op_t o_fu_alu_op,
    output procyon_pkg::procyon_data_t   o_fu_src_a,
    output procyon_pkg::procyon_data_t   o_fu_src_b,
    output procyon_pkg::procyon_tag_t    o_fu_tag
);

    localparam int IDX_WIDTH = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0]          entry_valid;
    logic [IDX_WIDTH-1:0]         entry_age      [0:RS_DEPTH-1];
    procyon_pkg::procyon_alu_op_t entry_alu_op   [0:RS_DEPTH-1];
    logic [1:0]                   entry_src_rdy  [0:RS_DEPTH-1];
    procyon_pkg::procyon_tag_t    entry_src_tag  [0:RS_DEPTH-1][0:1];
    procyon_pkg::procyon_data_t   entry_src_data [0:RS_DEPTH-1][0:1];
    procyon_pkg::procyon_tag_t    entry_dst_tag  [0:RS_DEPTH-1];
    logic                         alloc;
    logic [IDX_WIDTH-1:0]         alloc_idx;
    logic                         issue;
    logic [IDX_WIDTH-1:0]         issue_idx;

    assign rs_if.ready = ~&entry_valid;
    assign alloc       = rs_if.valid & rs_if.ready;

    // Lowest free slot
    always_comb begin
        alloc_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                alloc_idx = IDX_WIDTH'(i);
            end
        end
    end

    // Oldest entry with both sources ready has the highest age
    always_comb begin
        issue     = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (entry_valid[i] && (&entry_src_rdy[i]) &&
                (!issue || entry_age[i] > entry_age[issue_idx])) begin
                issue     = 1'b1;
                issue_idx = IDX_WIDTH'(i);
            end
        end
    end

    assign o_fu_valid  = issue;
    assign o_fu_alu_op = entry_alu_op[issue_idx];
    assign o_fu_src_a  = entry_src_data[issue_idx][0];
    assign o_fu_src_b  = entry_src_data[issue_idx][1];
    assign o_fu_tag    = entry_dst_tag[issue_idx];

    // Ages stay a permutation of 0 to the number of valid entries minus one
    always_ff @(posedge clk) begin
        if (i_reset) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (alloc && alloc_idx == IDX_WIDTH'(i)) begin
                    entry_valid[i] <= 1'b1;
                    entry_age[i]   <= '0;
                end else if (issue && issue_idx == IDX_WIDTH'(i)) begin
                    entry_valid[i] <= 1'b0;
                end else if (entry_valid[i]) begin
                    entry_age[i] <= entry_age[i] + IDX_WIDTH'(alloc) -
                                    IDX_WIDTH'(issue && entry_age[i] > entry_age[issue_idx]);
                end
            end
        end
    end

    // Sources are woken by the CDB, including one seen while being written
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (alloc && alloc_idx == IDX_WIDTH'(i)) begin
                entry_alu_op[i]  <= rs_if.alu_op;
                entry_dst_tag[i] <= rs_if.dst_tag;
                for (int s = 0; s < 2; s++) begin
                    entry_src_tag[i][s] <= rs_if.src_tag[s];
                    if (!rs_if.src_rdy[s] && i_cdb.valid && i_cdb.tag == rs_if.src_tag[s]) begin
                        entry_src_rdy[i][s]  <= 1'b1;
                        entry_src_data[i][s] <= i_cdb.data;
                    end else begin
                        entry_src_rdy[i][s]  <= rs_if.src_rdy[s];
                        entry_src_data[i][s] <= rs_if.src_data[s];
                    end
                end
            end else begin
                for (int s = 0; s < 2; s++) begin
                    if (!entry_src_rdy[i][s] && i_cdb.valid &&
                        i_cdb.tag == entry_src_tag[i][s]) begin
                        entry_src_rdy[i][s]  <= 1'b1;
                        entry_src_data[i][s] <= i_cdb.data;
                    end
                end
            end
        end
    end

endmodule

// ==== source/reorder_buffer.sv ====
`timescale 1ns/1ns
`include "procyon_defines.svh"

module reorder_buffer (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_rob_en,
    input  procyon_pkg::procyon_reg_t  i_rob_rdest,
    output logic                       o_rob_full,
    output procyon_pkg::procyon_tag_t  o_rob_tag,
    input  procyon_pkg::procyon_tag_t  i_lookup_tag [0:1],
    output logic                       o_src_rdy    [0:1],
    output procyon_pkg::procyon_data_t o_src_data   [0:1],
    input  procyon_pkg::procyon_cdb_t  i_cdb,
    output logic                       o_retire_en,
    output procyon_pkg::procyon_reg_t  o_retire_rdest,
    output procyon_pkg::procyon_tag_t  o_retire_tag,
    output procyon_pkg::procyon_data_t o_retire_data
);

    localparam int CNT_WIDTH = $clog2(`ROB_DEPTH) + 1;

    procyon_pkg::procyon_reg_t  rob_rdest [0:`ROB_DEPTH-1];
    procyon_pkg::procyon_data_t rob_data  [0:`ROB_DEPTH-1];
    logic [`ROB_DEPTH-1:0]      done;
    procyon_pkg::procyon_tag_t  head;
    procyon_pkg::procyon_tag_t  tail;
    logic [CNT_WIDTH-1:0]       count;
    logic                       alloc;
    logic                       retire;

    assign o_rob_full = (count == CNT_WIDTH'(`ROB_DEPTH));
    assign o_rob_tag  = tail;
    assign alloc      = i_rob_en & ~o_rob_full;
    assign retire     = (count != '0) & done[head];

    // Done stays set after retire until the slot is reallocated, which covers
    // the cycle before the register map sees the retire write
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_src_rdy[s]  = done[i_lookup_tag[s]];
            o_src_data[s] = rob_data[i_lookup_tag[s]];
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            done        <= '0;
            o_retire_en <= 1'b0;
        end else begin
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (i_cdb.valid) begin
                done[i_cdb.tag] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count       <= count + CNT_WIDTH'(alloc) - CNT_WIDTH'(retire);
            o_retire_en <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rob_rdest[tail] <= i_rob_rdest;
        end
        if (i_cdb.valid) begin
            rob_data[i_cdb.tag] <= i_cdb.data;
        end
        if (retire) begin
            o_retire_rdest <= rob_rdest[head];
            o_retire_tag   <= head;
            o_retire_data  <= (rob_rdest[head] == '0) ? '0 : rob_data[head];
        end
    end

endmodule

// ==== source/register_map.sv ====
`timescale 1ns/1ns
`include "procyon_defines.svh"

module register_map (
    input  logic                       clk,
    input  logic                       i_reset,
    input  procyon_pkg::procyon_reg_t  i_rsrc [0:1],
    output logic                       o_busy [0:1],
    output procyon_pkg::procyon_tag_t  o_tag  [0:1],
    output procyon_pkg::procyon_data_t o_data [0:1],
    input  logic                       i_rename_en,
    input  procyon_pkg::procyon_reg_t  i_rename_rdest,
    input  procyon_pkg::procyon_tag_t  i_rename_tag,
    input  logic                       i_retire_en,
    input  procyon_pkg::procyon_reg_t  i_retire_rdest,
    input  procyon_pkg::procyon_tag_t  i_retire_tag,
    input  procyon_pkg::procyon_data_t i_retire_data
);

    procyon_pkg::procyon_data_t regs    [0:`REG_COUNT-1];
    procyon_pkg::procyon_tag_t  reg_tag [0:`REG_COUNT-1];
    logic [`REG_COUNT-1:0]      reg_busy;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_busy[s] = reg_busy[i_rsrc[s]];
            o_tag[s]  = reg_tag[i_rsrc[s]];
            o_data[s] = regs[i_rsrc[s]];
        end
    end

    // x0 is never written and never renamed
    always_ff @(posedge clk) begin
        if (i_reset) begin
            reg_busy <= '0;
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (i_retire_en && i_retire_rdest != '0) begin
                regs[i_retire_rdest] <= i_retire_data;
                // Only the latest rename of this register frees it
                if (reg_tag[i_retire_rdest] == i_retire_tag) begin
                    reg_busy[i_retire_rdest] <= 1'b0;
                end
            end
            if (i_rename_en && i_rename_rdest != '0) begin
                reg_busy[i_rename_rdest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rename_en) begin
            reg_tag[i_rename_rdest] <= i_rename_tag;
        end
    end

endmodule

// ==== source/dispatch.sv ====
`timescale 1ns/1ns

module dispatch (
    input  logic                       i_insn_fifo_empty,
    input  procyon_pkg::procyon_insn_t i_insn_fifo_data,
    output logic                       o_insn_fifo_rd_en,

    output procyon_pkg::procyon_reg_t  o_regmap_rsrc [0:1],
    input  logic                       i_regmap_busy [0:1],
    input  procyon_pkg::procyon_tag_t  i_regmap_tag  [0:1],
    input  procyon_pkg::procyon_data_t i_regmap_data [0:1],
    output logic                       o_regmap_rename_en,
    output procyon_pkg::procyon_reg_t  o_regmap_rename_rdest,

    input  logic                       i_rob_full,
    input  procyon_pkg::procyon_tag_t  i_rob_tag,
    input  logic                       i_rob_src_rdy  [0:1],
    input  procyon_pkg::procyon_data_t i_rob_src_data [0:1],
    output procyon_pkg::procyon_tag_t  o_rob_lookup_tag [0:1],
    output logic                       o_rob_en,
    output procyon_pkg::procyon_reg_t  o_rob_rdest,

    rs_dispatch_if.dispatch            rs_if
);

    procyon_pkg::procyon_insn_t   insn;
    procyon_pkg::procyon_data_t   imm;
    procyon_pkg::procyon_reg_t    rdest;
    logic                         is_op;
    logic                         is_opimm;
    logic                         supported;
    logic                         dispatch_en;

    assign insn      = i_insn_fifo_data;
    assign is_op     = (insn.r.opcode == procyon_pkg::OPCODE_OP);
    assign is_opimm  = (insn.i.opcode == procyon_pkg::OPCODE_OPIMM);
    assign supported = is_op | is_opimm;
    assign imm       = {{($bits(procyon_pkg::procyon_data_t)-12){insn.i.imm12[11]}}, insn.i.imm12};
    assign rdest     = supported ? insn.r.rd : '0;

    // All three allocations happen at the same edge
    assign dispatch_en        = ~i_insn_fifo_empty & ~i_rob_full & rs_if.ready;
    assign o_insn_fifo_rd_en  = dispatch_en;
    assign o_rob_en           = dispatch_en;
    assign o_regmap_rename_en = dispatch_en;
    assign rs_if.valid        = dispatch_en;

    assign o_rob_rdest           = rdest;
    assign o_regmap_rename_rdest = rdest;
    assign rs_if.dst_tag         = i_rob_tag;
    assign o_regmap_rsrc[0]      = insn.r.rs1;
    assign o_regmap_rsrc[1]      = insn.r.rs2;

    always_comb begin
        rs_if.alu_op = procyon_pkg::ALU_ZERO;
        if (supported) begin
            case (insn.r.funct3)
                3'b000:  rs_if.alu_op = (is_op && insn.r.funct7[5]) ? procyon_pkg::ALU_SUB
                                                                    : procyon_pkg::ALU_ADD;
                3'b100:  rs_if.alu_op = procyon_pkg::ALU_XOR;
                3'b110:  rs_if.alu_op = procyon_pkg::ALU_OR;
                3'b111:  rs_if.alu_op = procyon_pkg::ALU_AND;
                default: rs_if.alu_op = procyon_pkg::ALU_ZERO;
            endcase
        end
    end

    // Source from register map, ROB forward, or a tag to wait on
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_rob_lookup_tag[s] = i_regmap_tag[s];
            rs_if.src_tag[s]    = i_regmap_tag[s];
            rs_if.src_rdy[s]    = 1'b1;
            rs_if.src_data[s]   = '0;
            if (!supported) begin
                rs_if.src_data[s] = '0;
            end else if (s == 1 && is_opimm) begin
                rs_if.src_data[s] = imm;
            end else if (!i_regmap_busy[s]) begin
                rs_if.src_data[s] = i_regmap_data[s];
            end else if (i_rob_src_rdy[s]) begin
                rs_if.src_data[s] = i_rob_src_data[s];
            end else begin
                rs_if.src_rdy[s] = 1'b0;
            end
        end
    end

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_fifo_wr_en,
    input  logic [DATA_WIDTH-1:0] i_fifo_data,
    output logic                  o_fifo_full,
    input  logic                  i_fifo_rd_en,
    output logic [DATA_WIDTH-1:0] o_fifo_data,
    output logic                  o_fifo_empty
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] fifo_mem [0:FIFO_DEPTH-1];
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH:0]    count;
    logic                  fifo_wr;
    logic                  fifo_rd;

    assign fifo_wr      = i_fifo_wr_en & ~o_fifo_full;
    assign fifo_rd      = i_fifo_rd_en & ~o_fifo_empty;
    assign o_fifo_full  = (count == (PTR_WIDTH+1)'(FIFO_DEPTH));
    assign o_fifo_empty = (count == '0);

    // Head is always visible
    assign o_fifo_data  = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            fifo_mem[wr_ptr] <= i_fifo_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_WIDTH+1)'(fifo_wr) - (PTR_WIDTH+1)'(fifo_rd);
        end
    end

endmodule

// ==== source/rs_dispatch_if.sv ====
`timescale 1ns/1ns

interface rs_dispatch_if;

    logic                         valid;
    logic                         ready;
    procyon_pkg::procyon_alu_op_t alu_op;
    logic                         src_rdy  [0:1];
    procyon_pkg::procyon_tag_t    src_tag  [0:1];
    procyon_pkg::procyon_data_t   src_data [0:1];
    procyon_pkg::procyon_tag_t    dst_tag;

    modport dispatch (
        output valid, alu_op, src_rdy, src_tag, src_data, dst_tag,
        input  ready
    );

    modport station (
        input  valid, alu_op, src_rdy, src_tag, src_data, dst_tag,
        output ready
    );

endinterface

// ==== source/procyon_pkg.sv ====
`include "procyon_defines.svh"

package procyon_pkg;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] procyon_tag_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] procyon_reg_t;
    typedef logic [`DATA_WIDTH-1:0]        procyon_data_t;

    typedef enum logic [6:0] {
        OPCODE_OP    = 7'b0110011,
        OPCODE_OPIMM = 7'b0010011
    } procyon_opcode_t;

    typedef struct packed {
        logic [6:0]      funct7;
        procyon_reg_t    rs2;
        procyon_reg_t    rs1;
        logic [2:0]      funct3;
        procyon_reg_t    rd;
        procyon_opcode_t opcode;
    } procyon_rtype_t;

    typedef struct packed {
        logic [11:0]     imm12;
        procyon_reg_t    rs1;
        logic [2:0]      funct3;
        procyon_reg_t    rd;
        procyon_opcode_t opcode;
    } procyon_itype_t;

    // Same instruction word, read as R-type or I-type depending on the opcode
    typedef union packed {
        procyon_rtype_t r;
        procyon_itype_t i;
    } procyon_insn_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_ZERO
    } procyon_alu_op_t;

    typedef struct packed {
        logic          valid;
        procyon_tag_t  tag;
        procyon_data_t data;
    } procyon_cdb_t;

endpackage

// ==== source/procyon_defines.svh ====
`ifndef PROCYON_DEFINES_SVH
`define PROCYON_DEFINES_SVH

// Data path and register file
`define DATA_WIDTH      32
`define REG_COUNT       32

// Reorder buffer depth also sets the rename tag width
`define ROB_DEPTH       8

// Queue depths
`define RS_DEPTH        4
`define INSN_FIFO_DEPTH 4

`endif
